// ==== hdl/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// SRAM depth in words, higher word indexes are out of range
`define MEM_WORDS 64

// ----------------------------------------------------------------------
// AXI response codes
// ----------------------------------------------------------------------
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== hdl/mem_pkg.sv ====
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

  // Bus payloads
  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_DATA_W-1:0] data_t;
  typedef logic [1:0]             resp_t;

  // SRAM word select, byte address bits 7:2
  typedef logic [5:0]             word_index_t;

  // Fetch handshake sequence
  typedef enum logic [1:0] {
    idle,
    wait_arready,
    wait_rvalid,
    wait_ready
  } fetch_state_t;

  // Load-store sequence
  typedef enum logic [2:0] {
    lsu_idle,
    lsu_read_addr,
    lsu_read_data,
    lsu_write_req,
    lsu_write_resp,
    lsu_respond
  } lsu_state_t;

  // Read arbiter lock
  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_controller.sv ====
`default_nettype none

module fetch_controller import mem_pkg::*; (
  input  logic clock,
  input  logic reset,

  // Upstream pc handshake
  input  logic valid_pre_i,
  output logic ready_pre_o,

  // Downstream instruction handshake
  output logic valid_post_o,
  input  logic ready_post_i,

  // Register load strobes
  output logic pc_we_o,
  output logic inst_we_o,

  // Read address channel
  input  logic arready_i,
  output logic arvalid_o,

  // Read data channel
  input  logic rvalid_i,
  output logic rready_o
);

  fetch_state_t state_q;
  fetch_state_t state_d;

  // ----------------------------------------------------------------------
  // Handshake outputs, decoded straight from the state
  // ----------------------------------------------------------------------
  assign ready_pre_o  = (state_q == idle);
  assign arvalid_o    = (state_q == wait_arready);
  assign rready_o     = (state_q == wait_rvalid);
  assign valid_post_o = (state_q == wait_ready);

  // Capture pc on accept, instruction on the R beat
  assign pc_we_o   = valid_pre_i && ready_pre_o;
  assign inst_we_o = rvalid_i && rready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Each state waits on exactly one handshake
  always_comb begin
    state_d = state_q;
    case (state_q)
      idle:         if (valid_pre_i)  state_d = wait_arready;
      wait_arready: if (arready_i)    state_d = wait_rvalid;
      wait_rvalid:  if (rvalid_i)     state_d = wait_ready;
      wait_ready:   if (ready_post_i) state_d = idle;
      default:                        state_d = idle;
    endcase
  end

  // Address request not withdrawn before the slave takes it
  arvalid_held: assert property (
    @(posedge clock) disable iff (reset)
    arvalid_o && !arready_i |=> arvalid_o
  );

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`default_nettype none

`include "mem_params.svh"

module fetch_unit import mem_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  // Program counter from upstream
  input  logic  pc_valid_i,
  input  addr_t pc_i,
  output logic  pc_ready_o,

  // Fetched instruction to downstream
  output logic  inst_valid_o,
  output data_t inst_o,
  output addr_t inst_pc_o,
  output logic  inst_err_o,
  input  logic  inst_ready_i,

  // AXI4-Lite read master
  output addr_t m_araddr_o,
  output logic  m_arvalid_o,
  input  logic  m_arready_i,
  input  data_t m_rdata_i,
  input  resp_t m_rresp_i,
  input  logic  m_rvalid_i,
  output logic  m_rready_o
);

  logic  pc_we;
  logic  inst_we;
  addr_t pc_q;
  data_t inst_q;
  logic  err_q;

  fetch_controller fetch_controller_inst (
    .clock        (clock),
    .reset        (reset),
    .valid_pre_i  (pc_valid_i),
    .ready_pre_o  (pc_ready_o),
    .valid_post_o (inst_valid_o),
    .ready_post_i (inst_ready_i),
    .pc_we_o      (pc_we),
    .inst_we_o    (inst_we),
    .arready_i    (m_arready_i),
    .arvalid_o    (m_arvalid_o),
    .rvalid_i     (m_rvalid_i),
    .rready_o     (m_rready_o)
  );

  // ----------------------------------------------------------------------
  // Payload registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (pc_we) begin
      pc_q <= pc_i;
    end
    if (inst_we) begin
      inst_q <= m_rdata_i;
      err_q  <= (m_rresp_i == `AXI_RESP_SLVERR);
    end
  end

  // pc stays put until the instruction is taken
  assign m_araddr_o = pc_q;
  assign inst_pc_o  = pc_q;
  assign inst_o     = inst_q;
  assign inst_err_o = err_q;

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`default_nettype none

`include "mem_params.svh"

module load_store_unit import mem_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  // Load and store requests
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,

  // Completion back to the requester
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o,

  // AXI4-Lite read master
  output addr_t m_araddr_o,
  output logic  m_arvalid_o,
  input  logic  m_arready_i,
  input  data_t m_rdata_i,
  input  resp_t m_rresp_i,
  input  logic  m_rvalid_i,
  output logic  m_rready_o,

  // AXI4-Lite write master
  output addr_t m_awaddr_o,
  output logic  m_awvalid_o,
  input  logic  m_awready_i,
  output data_t m_wdata_o,
  output logic  m_wvalid_o,
  input  logic  m_wready_i,
  input  resp_t m_bresp_i,
  input  logic  m_bvalid_i,
  output logic  m_bready_o
);

  lsu_state_t state_q;
  lsu_state_t state_d;

  addr_t addr_q;
  data_t wdata_q;
  data_t rdata_q;
  logic  err_q;

  logic  req_fire;
  logic  r_fire;
  logic  b_fire;

  // ----------------------------------------------------------------------
  // Handshakes decoded from the state
  // ----------------------------------------------------------------------
  assign req_ready_o = (state_q == lsu_idle);
  assign m_arvalid_o = (state_q == lsu_read_addr);
  assign m_rready_o  = (state_q == lsu_read_data);
  assign m_awvalid_o = (state_q == lsu_write_req);
  assign m_wvalid_o  = (state_q == lsu_write_req);
  assign m_bready_o  = (state_q == lsu_write_resp);
  assign rsp_valid_o = (state_q == lsu_respond);

  assign req_fire = req_valid_i && req_ready_o;
  assign r_fire   = m_rvalid_i && m_rready_o;
  assign b_fire   = m_bvalid_i && m_bready_o;

  // Registered request drives both address channels
  assign m_araddr_o  = addr_q;
  assign m_awaddr_o  = addr_q;
  assign m_wdata_o   = wdata_q;
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= lsu_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_idle:       if (req_valid_i) state_d = req_write_i ? lsu_write_req : lsu_read_addr;
      lsu_read_addr:  if (m_arready_i) state_d = lsu_read_data;
      lsu_read_data:  if (m_rvalid_i)  state_d = lsu_respond;
      // Slave takes address and data in the same cycle
      lsu_write_req:  if (m_awready_i && m_wready_i) state_d = lsu_write_resp;
      lsu_write_resp: if (m_bvalid_i)  state_d = lsu_respond;
      lsu_respond:    if (rsp_ready_i) state_d = lsu_idle;
      default:                         state_d = lsu_idle;
    endcase
  end

  // ----------------------------------------------------------------------
  // Request and response payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (req_fire) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
    if (r_fire) begin
      rdata_q <= m_rdata_i;
      err_q   <= (m_rresp_i == `AXI_RESP_SLVERR);
    end else if (b_fire) begin
      // Stores return no data
      rdata_q <= '0;
      err_q   <= (m_bresp_i == `AXI_RESP_SLVERR);
    end
  end

  // Write address and write data accepted as a pair
  aw_w_paired: assert property (
    @(posedge clock) disable iff (reset)
    m_awvalid_o && m_wvalid_o |-> m_awready_i == m_wready_i
  );

endmodule

`default_nettype wire

// ==== hdl/axi_lite_arbiter.sv ====
`default_nettype none

module axi_lite_arbiter import mem_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  // Read slave port 0, fetch unit
  input  addr_t s0_araddr_i,
  input  logic  s0_arvalid_i,
  output logic  s0_arready_o,
  output data_t s0_rdata_o,
  output resp_t s0_rresp_o,
  output logic  s0_rvalid_o,
  input  logic  s0_rready_i,

  // Read slave port 1, load-store unit
  input  addr_t s1_araddr_i,
  input  logic  s1_arvalid_i,
  output logic  s1_arready_o,
  output data_t s1_rdata_o,
  output resp_t s1_rresp_o,
  output logic  s1_rvalid_o,
  input  logic  s1_rready_i,

  // Write slave port, load-store unit only
  input  addr_t s1_awaddr_i,
  input  logic  s1_awvalid_i,
  output logic  s1_awready_o,
  input  data_t s1_wdata_i,
  input  logic  s1_wvalid_i,
  output logic  s1_wready_o,
  output resp_t s1_bresp_o,
  output logic  s1_bvalid_o,
  input  logic  s1_bready_i,

  // Master port toward the SRAM
  output addr_t m_araddr_o,
  output logic  m_arvalid_o,
  input  logic  m_arready_i,
  input  data_t m_rdata_i,
  input  resp_t m_rresp_i,
  input  logic  m_rvalid_i,
  output logic  m_rready_o,
  output addr_t m_awaddr_o,
  output logic  m_awvalid_o,
  input  logic  m_awready_i,
  output data_t m_wdata_o,
  output logic  m_wvalid_o,
  input  logic  m_wready_i,
  input  resp_t m_bresp_i,
  input  logic  m_bvalid_i,
  output logic  m_bready_o
);

  arb_state_t state_q;
  logic       grant_q;
  logic       prio_q;
  logic       grant;
  logic       arb_open;
  logic       write_open;

  // ----------------------------------------------------------------------
  // Grant select, 0 for fetch and 1 for load-store
  // ----------------------------------------------------------------------
  assign arb_open = (state_q == arb_idle);

  always_comb begin
    if (!arb_open) begin
      grant = grant_q;
    end else if (s0_arvalid_i && s1_arvalid_i) begin
      grant = prio_q;
    end else begin
      grant = s1_arvalid_i;
    end
  end

  // Address channel only while unlocked
  assign m_araddr_o   = grant ? s1_araddr_i : s0_araddr_i;
  assign m_arvalid_o  = arb_open && (grant ? s1_arvalid_i : s0_arvalid_i);
  assign s0_arready_o = arb_open && !grant && m_arready_i;
  assign s1_arready_o = arb_open && grant && m_arready_i;

  // Data channel steered to the locked owner
  assign m_rready_o  = !arb_open && (grant_q ? s1_rready_i : s0_rready_i);
  assign s0_rvalid_o = !arb_open && !grant_q && m_rvalid_i;
  assign s1_rvalid_o = !arb_open && grant_q && m_rvalid_i;
  assign s0_rdata_o  = m_rdata_i;
  assign s0_rresp_o  = m_rresp_i;
  assign s1_rdata_o  = m_rdata_i;
  assign s1_rresp_o  = m_rresp_i;

  // ----------------------------------------------------------------------
  // Write pass-through, held off during a read
  // ----------------------------------------------------------------------
  assign write_open   = arb_open && !m_arvalid_o;
  assign m_awaddr_o   = s1_awaddr_i;
  assign m_awvalid_o  = s1_awvalid_i && write_open;
  assign s1_awready_o = m_awready_i && write_open;
  assign m_wdata_o    = s1_wdata_i;
  assign m_wvalid_o   = s1_wvalid_i && write_open;
  assign s1_wready_o  = m_wready_i && write_open;
  assign s1_bresp_o   = m_bresp_i;
  assign s1_bvalid_o  = m_bvalid_i;
  assign m_bready_o   = s1_bready_i;

  // Lock on AR beat, release on R beat
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= arb_idle;
      grant_q <= 1'b0;
      prio_q  <= 1'b0;
    end else if (arb_open) begin
      if (m_arvalid_o && m_arready_i) begin
        state_q <= arb_locked;
        grant_q <= grant;
        // Other master wins the next tie
        prio_q  <= !grant;
      end
    end else if (m_rvalid_i && m_rready_o) begin
      state_q <= arb_idle;
    end
  end

  // Owner kept until its read data has gone through
  grant_stable: assert property (
    @(posedge clock) disable iff (reset)
    !arb_open && !(m_rvalid_i && m_rready_o) |=> !arb_open && $stable(grant_q)
  );

endmodule

`default_nettype wire

// ==== hdl/axi_lite_sram.sv ====
`default_nettype none

`include "mem_params.svh"

module axi_lite_sram import mem_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  // Read channels
  input  addr_t s_araddr_i,
  input  logic  s_arvalid_i,
  output logic  s_arready_o,
  output data_t s_rdata_o,
  output resp_t s_rresp_o,
  output logic  s_rvalid_o,
  input  logic  s_rready_i,

  // Write channels
  input  addr_t s_awaddr_i,
  input  logic  s_awvalid_i,
  output logic  s_awready_o,
  input  data_t s_wdata_i,
  input  logic  s_wvalid_i,
  output logic  s_wready_o,
  output resp_t s_bresp_o,
  output logic  s_bvalid_o,
  input  logic  s_bready_i
);

  localparam addr_t word_limit = addr_t'(`MEM_WORDS);

  data_t       mem [`MEM_WORDS];

  logic        rd_pend_q;
  data_t       rdata_q;
  resp_t       rresp_q;
  logic        wr_pend_q;
  resp_t       bresp_q;

  logic        ar_fire;
  logic        r_fire;
  logic        w_fire;
  logic        b_fire;
  logic        ar_in_range;
  logic        aw_in_range;
  word_index_t ar_index;
  word_index_t aw_index;

  // ----------------------------------------------------------------------
  // Address decode and range check
  // ----------------------------------------------------------------------
  assign ar_index    = s_araddr_i[7:2];
  assign aw_index    = s_awaddr_i[7:2];
  // Full word address compared, not just the index bits
  assign ar_in_range = (s_araddr_i >> 2) < word_limit;
  assign aw_in_range = (s_awaddr_i >> 2) < word_limit;

  // One read and one write in flight at most
  assign s_arready_o = !rd_pend_q;
  assign s_awready_o = s_awvalid_i && s_wvalid_i && !wr_pend_q;
  assign s_wready_o  = s_awvalid_i && s_wvalid_i && !wr_pend_q;

  assign ar_fire = s_arvalid_i && s_arready_o;
  assign r_fire  = s_rvalid_o && s_rready_i;
  assign w_fire  = s_awvalid_i && s_awready_o;
  assign b_fire  = s_bvalid_o && s_bready_i;

  assign s_rvalid_o = rd_pend_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = rresp_q;
  assign s_bvalid_o = wr_pend_q;
  assign s_bresp_o  = bresp_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        rd_pend_q <= 1'b1;
      end else if (r_fire) begin
        rd_pend_q <= 1'b0;
      end
      if (w_fire) begin
        wr_pend_q <= 1'b1;
      end else if (b_fire) begin
        wr_pend_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Word array and response payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    // Out-of-range stores dropped
    if (w_fire && aw_in_range) begin
      mem[aw_index] <= s_wdata_i;
    end
    if (w_fire) begin
      bresp_q <= aw_in_range ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
    end
    if (ar_fire) begin
      rdata_q <= ar_in_range ? mem[ar_index] : '0;
      rresp_q <= ar_in_range ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem_top.sv ====
`default_nettype none

module mem_subsystem_top import mem_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  // Fetch side
  input  logic  pc_valid_i,
  input  addr_t pc_i,
  output logic  pc_ready_o,
  output logic  inst_valid_o,
  output data_t inst_o,
  output addr_t inst_pc_o,
  output logic  inst_err_o,
  input  logic  inst_ready_i,

  // Load-store side
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o
);

  // ----------------------------------------------------------------------
  // Fetch read master, arbiter port 0
  // ----------------------------------------------------------------------
  addr_t f_araddr;
  logic  f_arvalid;
  logic  f_arready;
  data_t f_rdata;
  resp_t f_rresp;
  logic  f_rvalid;
  logic  f_rready;

  // ----------------------------------------------------------------------
  // Load-store master, arbiter port 1
  // ----------------------------------------------------------------------
  addr_t l_araddr;
  logic  l_arvalid;
  logic  l_arready;
  data_t l_rdata;
  resp_t l_rresp;
  logic  l_rvalid;
  logic  l_rready;
  addr_t l_awaddr;
  logic  l_awvalid;
  logic  l_awready;
  data_t l_wdata;
  logic  l_wvalid;
  logic  l_wready;
  resp_t l_bresp;
  logic  l_bvalid;
  logic  l_bready;

  // Arbiter to SRAM
  addr_t s_araddr;
  logic  s_arvalid;
  logic  s_arready;
  data_t s_rdata;
  resp_t s_rresp;
  logic  s_rvalid;
  logic  s_rready;
  addr_t s_awaddr;
  logic  s_awvalid;
  logic  s_awready;
  data_t s_wdata;
  logic  s_wvalid;
  logic  s_wready;
  resp_t s_bresp;
  logic  s_bvalid;
  logic  s_bready;

  fetch_unit fetch_unit_inst (
    .clock        (clock),
    .reset        (reset),
    .pc_valid_i   (pc_valid_i),
    .pc_i         (pc_i),
    .pc_ready_o   (pc_ready_o),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_err_o   (inst_err_o),
    .inst_ready_i (inst_ready_i),
    .m_araddr_o   (f_araddr),
    .m_arvalid_o  (f_arvalid),
    .m_arready_i  (f_arready),
    .m_rdata_i    (f_rdata),
    .m_rresp_i    (f_rresp),
    .m_rvalid_i   (f_rvalid),
    .m_rready_o   (f_rready)
  );

  load_store_unit load_store_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o),
    .m_araddr_o  (l_araddr),
    .m_arvalid_o (l_arvalid),
    .m_arready_i (l_arready),
    .m_rdata_i   (l_rdata),
    .m_rresp_i   (l_rresp),
    .m_rvalid_i  (l_rvalid),
    .m_rready_o  (l_rready),
    .m_awaddr_o  (l_awaddr),
    .m_awvalid_o (l_awvalid),
    .m_awready_i (l_awready),
    .m_wdata_o   (l_wdata),
    .m_wvalid_o  (l_wvalid),
    .m_wready_i  (l_wready),
    .m_bresp_i   (l_bresp),
    .m_bvalid_i  (l_bvalid),
    .m_bready_o  (l_bready)
  );

  axi_lite_arbiter axi_lite_arbiter_inst (
    .clock        (clock),
    .reset        (reset),
    .s0_araddr_i  (f_araddr),
    .s0_arvalid_i (f_arvalid),
    .s0_arready_o (f_arready),
    .s0_rdata_o   (f_rdata),
    .s0_rresp_o   (f_rresp),
    .s0_rvalid_o  (f_rvalid),
    .s0_rready_i  (f_rready),
    .s1_araddr_i  (l_araddr),
    .s1_arvalid_i (l_arvalid),
    .s1_arready_o (l_arready),
    .s1_rdata_o   (l_rdata),
    .s1_rresp_o   (l_rresp),
    .s1_rvalid_o  (l_rvalid),
    .s1_rready_i  (l_rready),
    .s1_awaddr_i  (l_awaddr),
    .s1_awvalid_i (l_awvalid),
    .s1_awready_o (l_awready),
    .s1_wdata_i   (l_wdata),
    .s1_wvalid_i  (l_wvalid),
    .s1_wready_o  (l_wready),
    .s1_bresp_o   (l_bresp),
    .s1_bvalid_o  (l_bvalid),
    .s1_bready_i  (l_bready),
    .m_araddr_o   (s_araddr),
    .m_arvalid_o  (s_arvalid),
    .m_arready_i  (s_arready),
    .m_rdata_i    (s_rdata),
    .m_rresp_i    (s_rresp),
    .m_rvalid_i   (s_rvalid),
    .m_rready_o   (s_rready),
    .m_awaddr_o   (s_awaddr),
    .m_awvalid_o  (s_awvalid),
    .m_awready_i  (s_awready),
    .m_wdata_o    (s_wdata),
    .m_wvalid_o   (s_wvalid),
    .m_wready_i   (s_wready),
    .m_bresp_i    (s_bresp),
    .m_bvalid_i   (s_bvalid),
    .m_bready_o   (s_bready)
  );

  axi_lite_sram axi_lite_sram_inst (
    .clock       (clock),
    .reset       (reset),
    .s_araddr_i  (s_araddr),
    .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready),
    .s_rdata_o   (s_rdata),
    .s_rresp_o   (s_rresp),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (s_rready),
    .s_awaddr_i  (s_awaddr),
    .s_awvalid_i (s_awvalid),
    .s_awready_o (s_awready),
    .s_wdata_i   (s_wdata),
    .s_wvalid_i  (s_wvalid),
    .s_wready_o  (s_wready),
    .s_bresp_o   (s_bresp),
    .s_bvalid_o  (s_bvalid),
    .s_bready_i  (s_bready)
  );

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsystem.sv ====
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsystem import mem_pkg::*; ();

  localparam int wait_limit = 200;

  logic  clock;
  logic  reset;
  logic  pc_valid_i;
  addr_t pc_i;
  logic  pc_ready_o;
  logic  inst_valid_o;
  data_t inst_o;
  addr_t inst_pc_o;
  logic  inst_err_o;
  logic  inst_ready_i;
  logic  req_valid_i;
  logic  req_ready_o;
  logic  req_write_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  logic  rsp_valid_o;
  logic  rsp_ready_i;
  data_t rsp_rdata_o;
  logic  rsp_err_o;

  logic [31:0] lfsr_q;
  data_t       model [`MEM_WORDS];
  int          errors;

  mem_subsystem_top mem_subsystem_top_inst (
    .clock        (clock),
    .reset        (reset),
    .pc_valid_i   (pc_valid_i),
    .pc_i         (pc_i),
    .pc_ready_o   (pc_ready_o),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_err_o   (inst_err_o),
    .inst_ready_i (inst_ready_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ----------------------------------------------------------------------
  // Failure reporting and value checks
  // ----------------------------------------------------------------------
  task automatic report_failure(input string reason);
    errors++;
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    string line;
    if (got !== expected) begin
      line = $sformatf("mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                       $time, name, got, expected);
      report_failure(line);
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  // ----------------------------------------------------------------------
  // Fetch path, starts and ends 1 unit after a rising edge
  // ----------------------------------------------------------------------
  task automatic fetch_word(input addr_t pc, input data_t exp_inst, input logic exp_err,
                            input int hold);
    int count;
    pc_valid_i = 1'b1;
    pc_i       = pc;
    count      = 0;
    while (!pc_ready_o) begin
      @(posedge clock);
      #1;
      count++;
      if (count > wait_limit) begin
        report_failure("timeout: fetch unit never accepted the pc");
      end
    end
    @(posedge clock);
    #1;
    pc_valid_i = 1'b0;
    count      = 0;
    while (!inst_valid_o) begin
      @(posedge clock);
      #1;
      count++;
      if (count > wait_limit) begin
        report_failure("timeout: fetch unit never returned an instruction");
      end
    end
    check_value("inst_o", inst_o, exp_inst);
    check_value("inst_pc_o", inst_pc_o, pc);
    check_value("inst_err_o", 32'(inst_err_o), 32'(exp_err));
    // Downstream stalls, output must not move
    repeat (hold) begin
      @(posedge clock);
      #1;
      check_value("inst_valid_o", 32'(inst_valid_o), 32'd1);
      check_value("inst_o", inst_o, exp_inst);
      check_value("inst_pc_o", inst_pc_o, pc);
      check_value("inst_err_o", 32'(inst_err_o), 32'(exp_err));
      check_value("pc_ready_o", 32'(pc_ready_o), 32'd0);
    end
    inst_ready_i = 1'b1;
    @(posedge clock);
    #1;
    inst_ready_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Load-store path, same timing convention
  // ----------------------------------------------------------------------
  task automatic lsu_access(input logic write, input addr_t addr, input data_t wdata,
                            input data_t exp_rdata, input logic exp_err, input int hold);
    int count;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    count       = 0;
    while (!req_ready_o) begin
      @(posedge clock);
      #1;
      count++;
      if (count > wait_limit) begin
        report_failure("timeout: load-store unit never accepted the request");
      end
    end
    @(posedge clock);
    #1;
    req_valid_i = 1'b0;
    count       = 0;
    while (!rsp_valid_o) begin
      @(posedge clock);
      #1;
      count++;
      if (count > wait_limit) begin
        report_failure("timeout: load-store unit never returned a response");
      end
    end
    check_value("rsp_rdata_o", rsp_rdata_o, exp_rdata);
    check_value("rsp_err_o", 32'(rsp_err_o), 32'(exp_err));
    repeat (hold) begin
      @(posedge clock);
      #1;
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd1);
      check_value("rsp_rdata_o", rsp_rdata_o, exp_rdata);
      check_value("rsp_err_o", 32'(rsp_err_o), 32'(exp_err));
      check_value("req_ready_o", 32'(req_ready_o), 32'd0);
    end
    rsp_ready_i = 1'b1;
    @(posedge clock);
    #1;
    rsp_ready_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    addr_t addr;
    addr_t pc;
    data_t value;
    int    hold;
    lfsr_q       = 32'd34;
    errors       = 0;
    reset        = 1'b1;
    pc_valid_i   = 1'b0;
    pc_i         = '0;
    inst_ready_i = 1'b0;
    req_valid_i  = 1'b0;
    req_write_i  = 1'b0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    rsp_ready_i  = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // Idle handshake levels
    check_value("pc_ready_o", 32'(pc_ready_o), 32'd1);
    check_value("req_ready_o", 32'(req_ready_o), 32'd1);
    check_value("inst_valid_o", 32'(inst_valid_o), 32'd0);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);

    // Fill every word, low address bits random
    for (int w = 0; w < `MEM_WORDS; w++) begin
      addr  = (addr_t'(w) << 2) | rand_bits(2);
      value = rand_bits(32);
      lsu_access(1'b1, addr, value, '0, 1'b0, 0);
      model[w[5:0]] = value;
    end
    for (int i = 0; i < 40; i++) begin
      addr  = rand_bits(8);
      value = rand_bits(32);
      lsu_access(1'b1, addr, value, '0, 1'b0, 0);
      model[addr[7:2]] = value;
    end
    for (int i = 0; i < 40; i++) begin
      addr = rand_bits(8);
      lsu_access(1'b0, addr, '0, model[addr[7:2]], 1'b0, 0);
    end

    // Instruction reads
    for (int i = 0; i < 40; i++) begin
      pc = rand_bits(8);
      fetch_word(pc, model[pc[7:2]], 1'b0, 0);
    end

    // Both masters raise requests in the same cycle
    for (int i = 0; i < 30; i++) begin
      pc   = rand_bits(8);
      addr = rand_bits(8);
      fork
        fetch_word(pc, model[pc[7:2]], 1'b0, 0);
        lsu_access(1'b0, addr, '0, model[addr[7:2]], 1'b0, 0);
      join
    end

    // Above the SRAM, upper address bits nonzero
    for (int i = 0; i < 8; i++) begin
      addr = (rand_bits(24) | 32'd1) << 8;
      addr = addr | rand_bits(8);
      lsu_access(1'b0, addr, '0, '0, 1'b1, 0);
      fetch_word(addr, '0, 1'b1, 0);
      value = rand_bits(32);
      lsu_access(1'b1, addr, value, '0, 1'b1, 0);
      // Aliased in-range word keeps its old value
      lsu_access(1'b0, addr & 32'hff, '0, model[addr[7:2]], 1'b0, 0);
    end

    // Consumers stall for a few cycles
    for (int i = 0; i < 12; i++) begin
      pc   = rand_bits(8);
      hold = 1 + int'(rand_bits(3));
      fetch_word(pc, model[pc[7:2]], 1'b0, hold);
      addr = rand_bits(8);
      hold = 1 + int'(rand_bits(3));
      lsu_access(1'b0, addr, '0, model[addr[7:2]], 1'b0, hold);
      addr  = rand_bits(8);
      value = rand_bits(32);
      hold  = 1 + int'(rand_bits(3));
      lsu_access(1'b1, addr, value, '0, 1'b0, hold);
      model[addr[7:2]] = value;
    end

    if (errors == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure("checks failed before the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/fetch_controller.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/axi_lite_arbiter.sv
hdl/axi_lite_sram.sv
hdl/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

// ==== Makefile ====
TOP = tb_mem_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
